//--- filelist.f
source/com_pkg.sv
source/crc5.sv
source/com_rx.sv
source/frame_dispatch.sv
source/com_tx.sv
source/com_link_top.sv
tests/com_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module com_link_tb -f filelist.f

output=$(./obj_dir/Vcom_link_tb)
echo "$output"

if grep -qF -- '*** PASSED ***' <<< "$output"; then
    exit 0
fi
exit 1

//--- source/com_link_top.sv
`timescale 1ns/1ps

module com_link_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            rx_byte,
    output logic [7:0]            tx_byte,
    output com_pkg::com_cfg_t     cfg,
    output logic                  cfg_update,
    output com_pkg::peer_status_t peer
);
    import com_pkg::*;

    rx_frame_t  frame;
    logic       fs;
    logic       fd;
    logic       reply_req;
    logic [7:0] reply_pid;

    com_rx u_rx (
        .clk     (clk),
        .rst     (rst),
        .rx_byte (rx_byte),
        .fs      (fs),
        .fd      (fd),
        .frame   (frame)
    );

    frame_dispatch u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .fs         (fs),
        .fd         (fd),
        .frame      (frame),
        .cfg        (cfg),
        .cfg_update (cfg_update),
        .peer       (peer),
        .reply_req  (reply_req),
        .reply_pid  (reply_pid)
    );

    com_tx u_tx (
        .clk       (clk),
        .rst       (rst),
        .reply_req (reply_req),
        .reply_pid (reply_pid),
        .tx_byte   (tx_byte)
    );

endmodule

//--- source/com_pkg.sv
package com_pkg;

    // pid bytes of the link.
    localparam logic [7:0] PID_SYNC = 8'h01;
    localparam logic [7:0] PID_CMD  = 8'h1E;
    localparam logic [7:0] PID_ACK  = 8'h2D;
    localparam logic [7:0] PID_NAK  = 8'hA5;
    localparam logic [7:0] PID_STL  = 8'hE1;

    // head nibble of the first payload byte.
    localparam logic [3:0] HEAD_DIDX   = 4'h9;
    localparam logic [3:0] HEAD_DDIDX  = 4'h1;
    localparam logic [3:0] HEAD_DPARAM = 4'h5;

    localparam int LEN_BYTES = 2; // the low nibble of the last one is the payload count.

    localparam logic [4:0] CRC_POLY = 5'h05; // x^5 + x^2 + 1.
    localparam logic [4:0] CRC_INIT = 5'h1f;

    localparam logic [7:0] IDLE_BYTE = 8'h00;

    typedef enum logic [3:0] {
        KIND_NONE   = 4'b0000,
        KIND_ACK    = 4'b0001,
        KIND_NAK    = 4'b0010,
        KIND_STL    = 4'b0011,
        KIND_DIDX   = 4'b0101,
        KIND_DPARAM = 4'b0110,
        KIND_DDIDX  = 4'b0111,
        KIND_ERROR  = 4'b1111
    } frame_kind_t;

    typedef struct packed {
        logic [3:0] device_idx;
        logic [3:0] data_idx;
        logic [3:0] freq_samp;
        logic [3:0] filt_up;
        logic [3:0] filt_low;
    } com_cfg_t;

    // result of one parsed frame, with the nibbles the parser captured.
    typedef struct packed {
        frame_kind_t kind;
        com_cfg_t    fields;
    } rx_frame_t;

    typedef struct packed {
        logic ack;
        logic nak;
        logic stall;
    } peer_status_t;

endpackage

//--- source/com_rx.sv
`timescale 1ns/1ps

module com_rx (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        rx_byte,
    output logic              fs,
    input  logic              fd,
    output com_pkg::rx_frame_t frame
);
    import com_pkg::*;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_WAIT,
        ST_PID,
        ST_LEN,
        ST_DATA,
        ST_CRC,
        ST_DONE,
        ST_ERR
    } rx_state_t;

    rx_state_t   state_q, state_d;
    logic [3:0]  cnt_q;    // byte index within the length or payload field.
    logic [3:0]  len_q;    // payload count from the last length byte.
    frame_kind_t kind_q;
    com_cfg_t    fields_q;

    logic       last_len;
    logic       crc_clear;
    logic       crc_en;
    logic [7:0] crc;

    assign last_len  = (state_q == ST_LEN) && (cnt_q == 4'(LEN_BYTES - 1));
    assign crc_clear = (state_q == ST_WAIT) && (rx_byte == PID_SYNC);
    assign crc_en    = last_len || (state_q == ST_DATA);

    assign fs           = (state_q == ST_DONE);
    assign frame.kind   = kind_q;
    assign frame.fields = fields_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_INIT: state_d = ST_WAIT;
            ST_WAIT: begin
                if (rx_byte == PID_SYNC) state_d = ST_PID;
            end
            ST_PID: begin
                case (rx_byte)
                    PID_CMD:                   state_d = ST_LEN;
                    PID_ACK, PID_NAK, PID_STL: state_d = ST_DONE;
                    default:                   state_d = ST_ERR;
                endcase
            end
            ST_LEN: begin
                // an empty payload cannot carry a head, so it is a broken frame.
                if (last_len) state_d = (rx_byte[3:0] == 4'h0) ? ST_ERR : ST_DATA;
            end
            ST_DATA: begin
                if (cnt_q == len_q - 4'd1) state_d = ST_CRC;
            end
            ST_CRC:  state_d = (rx_byte == crc) ? ST_DONE : ST_ERR;
            ST_DONE: begin
                if (fd) state_d = ST_WAIT;
            end
            ST_ERR:  state_d = ST_DONE;
            default: state_d = ST_INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= 4'd0;
        end else if (state_d != state_q) begin
            cnt_q <= 4'd0;
        end else if (state_q == ST_LEN || state_q == ST_DATA) begin
            cnt_q <= cnt_q + 4'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kind_q <= KIND_NONE;
        end else begin
            case (state_q)
                ST_PID: begin
                    case (rx_byte)
                        PID_ACK: kind_q <= KIND_ACK;
                        PID_NAK: kind_q <= KIND_NAK;
                        PID_STL: kind_q <= KIND_STL;
                        default: kind_q <= KIND_NONE; // a command until its head is seen.
                    endcase
                end
                ST_DATA: begin
                    if (cnt_q == 4'd0) begin
                        case (rx_byte[7:4])
                            HEAD_DIDX:   kind_q <= KIND_DIDX;
                            HEAD_DDIDX:  kind_q <= KIND_DDIDX;
                            HEAD_DPARAM: kind_q <= KIND_DPARAM;
                            default:     kind_q <= KIND_NONE;
                        endcase
                    end
                end
                ST_ERR:  kind_q <= KIND_ERROR;
                default: kind_q <= kind_q;
            endcase
        end
    end

    // captured nibbles are only read back for the fields a kind names.
    always_ff @(posedge clk) begin
        if (last_len) len_q <= rx_byte[3:0];
        if (state_q == ST_DATA && cnt_q == 4'd0) begin
            case (rx_byte[7:4])
                HEAD_DIDX:   fields_q.device_idx <= rx_byte[3:0];
                HEAD_DDIDX:  fields_q.data_idx   <= rx_byte[3:0];
                HEAD_DPARAM: fields_q.freq_samp  <= rx_byte[3:0];
                default:     fields_q            <= fields_q;
            endcase
        end
        if (state_q == ST_DATA && cnt_q == 4'd1 && kind_q == KIND_DPARAM) begin
            fields_q.filt_up  <= rx_byte[7:4];
            fields_q.filt_low <= rx_byte[3:0];
        end
    end

    crc5 u_crc5 (
        .clk    (clk),
        .rst    (rst),
        .clear  (crc_clear),
        .enable (crc_en),
        .din    (rx_byte),
        .crc    (crc)
    );

    // the finished frame is held, and the dispatcher takes it on the next edge.
    assert property (@(posedge clk) disable iff (rst) fs && !fd |=> fs && fd);

endmodule

//--- source/com_tx.sv
`timescale 1ns/1ps

module com_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       reply_req,
    input  logic [7:0] reply_pid,
    output logic [7:0] tx_byte
);
    import com_pkg::*;

    logic       pid_pending; // high while sync is on the line.
    logic [7:0] pid_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pid_pending <= 1'b0;
            tx_byte     <= IDLE_BYTE;
        end else if (reply_req) begin
            pid_pending <= 1'b1;
            tx_byte     <= PID_SYNC;
        end else if (pid_pending) begin
            pid_pending <= 1'b0;
            tx_byte     <= pid_q;
        end else begin
            tx_byte <= IDLE_BYTE;
        end
    end

    always_ff @(posedge clk) begin
        if (reply_req) pid_q <= reply_pid;
    end

    // the frame spacing on the input keeps replies from overlapping.
    assert property (@(posedge clk) disable iff (rst) pid_pending |-> !reply_req);

endmodule

//--- source/crc5.sv
`timescale 1ns/1ps

module crc5 (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       enable,
    input  logic [7:0] din,
    output logic [7:0] crc
);
    import com_pkg::*;

    logic [4:0] crc_q;

    // one byte folded in msb first, one bit step per loop pass.
    function automatic logic [4:0] crc_byte(input logic [4:0] c, input logic [7:0] d);
        logic [4:0] r;
        logic       fb;
        r = c;
        for (int i = 7; i >= 0; i--) begin
            fb = r[4] ^ d[i];
            r  = {r[3:0], 1'b0} ^ (fb ? CRC_POLY : 5'h00);
        end
        return r;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_q <= CRC_INIT;
        end else if (clear) begin
            crc_q <= CRC_INIT;
        end else if (enable) begin
            crc_q <= crc_byte(crc_q, din);
        end
    end

    assign crc = {3'b000, crc_q}; // sent with the top three bits zero.

    // the parser presets at sync and only folds later bytes of the frame.
    assert property (@(posedge clk) disable iff (rst) !(clear && enable));

endmodule

//--- source/frame_dispatch.sv
`timescale 1ns/1ps

module frame_dispatch (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fs,
    output logic                 fd,
    input  com_pkg::rx_frame_t   frame,
    output com_pkg::com_cfg_t    cfg,
    output logic                 cfg_update,
    output com_pkg::peer_status_t peer,
    output logic                 reply_req,
    output logic [7:0]           reply_pid
);
    import com_pkg::*;

    logic         cap;      // first edge of a finished frame.
    com_cfg_t     cfg_d;
    logic         upd_d;
    logic         req_d;
    logic [7:0]   pid_d;
    peer_status_t peer_d;

    assign cap = fs && !fd;

    always_comb begin
        cfg_d  = cfg;
        upd_d  = 1'b0;
        req_d  = 1'b0;
        pid_d  = PID_NAK;
        peer_d = '0;
        case (frame.kind)
            KIND_DIDX: begin
                cfg_d.device_idx = frame.fields.device_idx;
                upd_d = 1'b1;
            end
            KIND_DDIDX: begin
                cfg_d.data_idx = frame.fields.data_idx;
                upd_d = 1'b1;
            end
            KIND_DPARAM: begin
                cfg_d.freq_samp = frame.fields.freq_samp;
                cfg_d.filt_up   = frame.fields.filt_up;
                cfg_d.filt_low  = frame.fields.filt_low;
                upd_d = 1'b1;
            end
            KIND_ACK: peer_d.ack   = 1'b1;
            KIND_NAK: peer_d.nak   = 1'b1;
            KIND_STL: peer_d.stall = 1'b1;
            default:  req_d = 1'b1; // unknown head or a broken frame.
        endcase
        if (upd_d) begin
            req_d = 1'b1;
            pid_d = PID_ACK;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd         <= 1'b0;
            cfg        <= '0;
            cfg_update <= 1'b0;
            reply_req  <= 1'b0;
            peer       <= '0;
        end else begin
            fd         <= cap;
            cfg_update <= cap && upd_d;
            reply_req  <= cap && req_d;
            peer       <= cap ? peer_d : '0;
            if (cap) cfg <= cfg_d;
        end
    end

    always_ff @(posedge clk) begin
        if (cap) reply_pid <= pid_d; // only looked at with reply_req.
    end

endmodule

//--- tests/com_link_tb.sv
`timescale 1ns/1ps

module com_link_tb;
    import com_pkg::*;

    localparam int FRAMES          = 29;
    localparam int MAX_FRAME_BYTES = 20;
    localparam int GAP_BYTES       = 12; // idle bytes after a frame plus the reply drain.
    localparam int WATCHDOG_NS     = 2 * (FRAMES * (MAX_FRAME_BYTES + GAP_BYTES) + 16) * 10;
    localparam int RESP_CYCLES     = 40;

    logic         clk;
    logic         rst;
    logic [7:0]   rx_byte;
    logic [7:0]   tx_byte;
    com_cfg_t     cfg;
    logic         cfg_update;
    peer_status_t peer;

    com_cfg_t     exp_cfg;
    logic [7:0]   exp_pid;  // IDLE_BYTE when the current frame gets no reply.
    peer_status_t exp_peer;
    string        test_name;
    int           errors;
    int           tests_run;
    int           tests_failed;
    logic [31:0]  lfsr_q;
    logic [7:0]   frame_q[$];

    com_link_top uut (
        .clk        (clk),
        .rst        (rst),
        .rx_byte    (rx_byte),
        .tx_byte    (tx_byte),
        .cfg        (cfg),
        .cfg_update (cfg_update),
        .peer       (peer)
    );

    always #5 clk = ~clk;

    task automatic report_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        errors++;
        $display("FAILED %s: %s expected %h, actual %h", test_name, what, expected, actual);
    endtask

    task automatic report_other(input string msg);
        errors++;
        $display("test %s: %s", test_name, msg);
    endtask

    cfg_on_update: assert property (@(posedge clk) disable iff (rst)
        cfg_update |-> cfg == exp_cfg)
        else report_value("cfg", 32'($sampled(exp_cfg)), 32'($sampled(cfg)));
    update_only_on_ack: assert property (@(posedge clk) disable iff (rst)
        cfg_update |-> exp_pid == PID_ACK)
        else report_other("cfg_update pulsed for a frame that is not acknowledged");
    cfg_only_with_update: assert property (@(posedge clk) disable iff (rst)
        !$stable(cfg) |-> cfg_update)
        else report_other("cfg changed without a cfg_update pulse");
    sync_after_update: assert property (@(posedge clk) disable iff (rst)
        $past(cfg_update) |-> tx_byte == PID_SYNC)
        else report_value("reply sync", 32'(PID_SYNC), 32'($sampled(tx_byte)));
    pid_after_sync: assert property (@(posedge clk) disable iff (rst)
        $past(tx_byte) == PID_SYNC |-> tx_byte == exp_pid)
        else report_value("reply pid", 32'($sampled(exp_pid)), 32'($sampled(tx_byte)));
    tx_quiet: assert property (@(posedge clk) disable iff (rst)
        exp_pid == IDLE_BYTE |-> tx_byte == IDLE_BYTE)
        else report_other("tx_byte left idle although no reply was due");
    peer_match: assert property (@(posedge clk) disable iff (rst)
        peer != '0 |-> peer == exp_peer)
        else report_value("peer", 32'($sampled(exp_peer)), 32'($sampled(peer)));
    peer_one_cycle: assert property (@(posedge clk) disable iff (rst)
        peer != '0 |=> peer == '0)
        else report_other("a peer pulse lasted longer than one cycle");

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1.
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[6:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // crc-5 over one byte, msb first, straight from the polynomial.
    function automatic logic [4:0] crc_fold(input logic [4:0] c, input logic [7:0] b);
        logic [4:0] r;
        r = c;
        for (int i = 7; i >= 0; i--) begin
            if (r[4] != b[i]) begin
                r = (r << 1) ^ CRC_POLY;
            end else begin
                r = r << 1;
            end
        end
        return r;
    endfunction

    task automatic drive_frame();
        foreach (frame_q[i]) begin
            @(posedge clk);
            rx_byte <= frame_q[i];
        end
        repeat (4) begin
            @(posedge clk);
            rx_byte <= IDLE_BYTE;
        end
    endtask

    // what: 0 cfg_update, 1 sync on tx_byte, 2 tx_byte idle again, 3 any peer bit.
    task automatic await_event(input int what, input string desc);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < RESP_CYCLES && !seen; i++) begin
            @(negedge clk);
            case (what)
                0:       seen = cfg_update;
                1:       seen = (tx_byte == PID_SYNC);
                2:       seen = (tx_byte == IDLE_BYTE);
                default: seen = (peer != '0);
            endcase
        end
        if (!seen) report_other($sformatf("no %s within %0d cycles", desc, RESP_CYCLES));
    endtask

    task automatic watch_response();
        if (exp_pid == PID_ACK) await_event(0, "cfg_update arrived");
        if (exp_pid != IDLE_BYTE) begin
            await_event(1, "reply sync appeared on tx_byte");
            await_event(2, "return of tx_byte to idle");
        end else begin
            await_event(3, "peer pulse arrived");
        end
    endtask

    task automatic run_frame(input string name);
        int errors_before;
        errors_before = errors;
        test_name     = name;
        fork
            drive_frame();
            watch_response();
        join
        @(negedge clk);
        assert (cfg == exp_cfg) else report_value("cfg held", 32'(exp_cfg), 32'(cfg));
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic run_command(input string name, input logic [7:0] b0, input logic [7:0] b1,
                               input logic [3:0] count, input logic [3:0] len_hi,
                               input bit corrupt);
        logic [4:0] c;
        logic [7:0] pb;
        frame_q.delete();
        frame_q.push_back(PID_SYNC);
        frame_q.push_back(PID_CMD);
        frame_q.push_back(8'h00);
        frame_q.push_back({len_hi, count});
        c = crc_fold(CRC_INIT, {len_hi, count});
        for (int i = 0; i < int'(count); i++) begin
            if (i == 0) begin
                pb = b0;
            end else if (i == 1) begin
                pb = b1;
            end else begin
                pb = take_bits(8); // filler that only the crc sees.
            end
            frame_q.push_back(pb);
            c = crc_fold(c, pb);
        end
        frame_q.push_back({3'b000, c} ^ (corrupt ? 8'h01 : 8'h00));
        exp_pid  = PID_NAK;
        exp_peer = '0;
        if (!corrupt) begin
            case (b0[7:4])
                HEAD_DIDX: begin
                    exp_cfg.device_idx = b0[3:0];
                    exp_pid            = PID_ACK;
                end
                HEAD_DDIDX: begin
                    exp_cfg.data_idx = b0[3:0];
                    exp_pid          = PID_ACK;
                end
                HEAD_DPARAM: begin
                    exp_cfg.freq_samp = b0[3:0];
                    exp_cfg.filt_up   = b1[7:4];
                    exp_cfg.filt_low  = b1[3:0];
                    exp_pid           = PID_ACK;
                end
                default: ;
            endcase
        end
        run_frame(name);
    endtask

    task automatic run_short_frame(input string name, input logic [7:0] pid,
                                   input logic [7:0] reply, input peer_status_t bits);
        frame_q.delete();
        frame_q.push_back(PID_SYNC);
        frame_q.push_back(pid);
        exp_pid  = reply;
        exp_peer = bits;
        run_frame(name);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [1:0] sel;
        logic [3:0] head;
        logic [3:0] value;
        logic [3:0] count;
        logic [3:0] len_hi;
        logic [7:0] second;
        clk          = 1'b0;
        rst          = 1'b1;
        rx_byte      = IDLE_BYTE;
        exp_cfg      = '0;
        exp_pid      = IDLE_BYTE;
        exp_peer     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lfsr_q       = 32'hc161bb25;
        test_name    = "reset";
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(negedge clk);

        run_command("didx", {HEAD_DIDX, 4'h6}, 8'h00, 4'd1, 4'h0, 1'b0);
        run_command("ddidx", {HEAD_DDIDX, 4'ha}, 8'h00, 4'd1, 4'h0, 1'b0);
        run_command("dparam", {HEAD_DPARAM, 4'h3}, 8'hc7, 4'd2, 4'h0, 1'b0);
        run_command("bad_crc", {HEAD_DIDX, 4'hf}, 8'h00, 4'd1, 4'h0, 1'b1);
        run_command("bad_head", {4'h7, 4'h2}, 8'h44, 4'd3, 4'h0, 1'b0);
        run_short_frame("bad_pid", 8'h3c, PID_NAK, '0);
        run_short_frame("peer_ack", PID_ACK, IDLE_BYTE, '{ack: 1'b1, nak: 1'b0, stall: 1'b0});
        run_short_frame("peer_nak", PID_NAK, IDLE_BYTE, '{ack: 1'b0, nak: 1'b1, stall: 1'b0});
        run_short_frame("peer_stl", PID_STL, IDLE_BYTE, '{ack: 1'b0, nak: 1'b0, stall: 1'b1});

        for (int i = 0; i < 20; i++) begin
            sel = 2'(take_bits(2));
            case (sel)
                2'd0:    head = HEAD_DIDX;
                2'd1:    head = HEAD_DDIDX;
                2'd2:    head = HEAD_DPARAM;
                default: head = 4'(take_bits(4));
            endcase
            value  = 4'(take_bits(4));
            count  = 4'(take_bits(4));
            len_hi = 4'(take_bits(4));
            second = take_bits(8);
            if (count == 4'd0) count = 4'd1;
            // the filter nibbles ride in the second payload byte.
            if (head == HEAD_DPARAM && count < 4'd2) count = 4'd2;
            run_command($sformatf("random_%0d", i), {head, value}, second, count, len_hi, 1'b0);
        end

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
